//--- Bender.yml
package:
  name: sdram_ctrl

sources:
  - files:
      - hw/sdram_pkg.sv
      - hw/sync_parallel_counter.sv
      - hw/sdram_ref.sv
      - hw/sdram_init.sv
      - hw/sdram_refresh_timer.sv
      - hw/sdram_ctrl_top.sv
  - target: simulation
    files:
      - sim/sdram_sva.sv
      - sim/tb_sdram.sv

//--- hw/sdram_ctrl_top.sv
/*
 * Command side of the SDR SDRAM controller. Runs power-up init, then
 * periodic auto refresh, and drives the SDRAM command and address pins.
 * The init sequencer owns the pins until ready, the refresh one after.
 */
`default_nettype none

module sdram_ctrl_top (
    input  wire logic        clock,
    input  wire logic        reset,
    output logic             ready,
    output logic             refresh_active,
    output logic             dram_cke,
    output logic             dram_cs_n,
    output logic             dram_ras_n,
    output logic             dram_cas_n,
    output logic             dram_we_n,
    output logic [12:0]      dram_addr,
    output logic [1:0]       dram_ba
);

    import sdram_pkg::*;

    logic [3:0]  init_cmd;
    sdram_addr_u init_addr;
    logic        init_done;
    logic [3:0]  ref_cmd;
    sdram_addr_u ref_addr;
    logic        ref_request;
    logic        ref_end;
    logic [3:0]  pin_cmd;

    sdram_init sdram_init_inst (
        .clock     (clock),
        .reset     (reset),
        .init_cmd  (init_cmd),
        .init_addr (init_addr),
        .init_done (init_done)
    );

    sdram_refresh_timer sdram_refresh_timer_inst (
        .clock       (clock),
        .reset       (reset),
        .run         (init_done),
        .ref_end     (ref_end),
        .ref_request (ref_request)
    );

    sdram_ref sdram_ref_inst (
        .clock     (clock),
        .reset     (reset),
        .enable    (ref_request),
        .end_ref   (ref_end),
        .dram_cmd  (ref_cmd),
        .dram_addr (ref_addr)
    );

    always_ff @(posedge clock or posedge reset) begin
        if (reset) dram_cke <= 1'b0;
        else       dram_cke <= 1'b1;  // Clock enabled once out of reset
    end

    // Pin owner switches on init_done
    assign pin_cmd   = init_done ? ref_cmd : init_cmd;
    assign dram_addr = init_done ? ref_addr.raw : init_addr.raw;
    assign {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n} = pin_cmd;
    assign dram_ba   = 2'b00;

    assign ready          = init_done;
    assign refresh_active = ref_request;

endmodule

`default_nettype wire

//--- hw/sdram_init.sv
/*
 * Power-up initialisation sequencer. Waits 100 us of NOPs, then runs
 * PALL, two auto refreshes and a mode register set with their NOP gaps.
 * init_done rises after the tMRD gap and stays high until reset.
 */
`default_nettype none

module sdram_init (
    input  wire logic               clock,
    input  wire logic               reset,
    output logic [3:0]              init_cmd,
    output sdram_pkg::sdram_addr_u  init_addr,
    output logic                    init_done
);

    import sdram_pkg::*;

    logic [state_width-1:0]     state;
    logic [state_width-1:0]     next_state;
    logic [init_wait_width-1:0] wait_cnt;
    logic                       second_ref;   // First REF already done
    logic                       nop_cnt_rst;
    logic [cnt_width-1:0]       nop_cnt;
    logic                       wait_end;
    logic                       pall_nop_end;
    logic                       ref_nop_end;
    logic                       mrd_nop_end;

    assign wait_end     = (wait_cnt == t_init_wait - 1'b1);
    assign pall_nop_end = (nop_cnt >= t_rp_nops - 1'b1);
    assign ref_nop_end  = (nop_cnt >= t_rc_nops - 1'b1);
    assign mrd_nop_end  = (nop_cnt >= t_mrd_nops - 1'b1);
    assign init_done    = (state == init_st_done);

    sync_parallel_counter #(
        .size       (cnt_width),
        .init_value ('0)
    ) nop_counter (
        .clock      (clock),
        .reset      (nop_cnt_rst),
        .load       (1'b0),
        .load_value ('0),
        .enable     (1'b1),
        .value      (nop_cnt)
    );

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= init_st_wait;
            wait_cnt   <= '0;
            second_ref <= 1'b0;
        end else begin
            state <= next_state;
            if (state == init_st_wait) wait_cnt <= wait_cnt + 1'b1;
            if (state == init_st_ref_nop && ref_nop_end) second_ref <= 1'b1;
        end
    end

    always_comb begin
        next_state  = state;
        init_cmd    = cmd_nop;
        init_addr   = '0;
        nop_cnt_rst = 1'b0;
        case (state)
            init_st_wait: begin
                nop_cnt_rst = 1'b1;
                if (wait_end) next_state = init_st_pall;
            end
            init_st_pall: begin
                init_cmd          = cmd_pall;
                init_addr.raw[10] = 1'b1;  // All banks
                nop_cnt_rst       = 1'b1;
                next_state        = init_st_pall_nop;
            end
            init_st_pall_nop: if (pall_nop_end) next_state = init_st_ref;
            init_st_ref: begin
                init_cmd    = cmd_ref;
                nop_cnt_rst = 1'b1;
                next_state  = init_st_ref_nop;
            end
            init_st_ref_nop: begin
                if (ref_nop_end) next_state = second_ref ? init_st_mrs : init_st_ref;
            end
            init_st_mrs: begin
                init_cmd                     = cmd_mrs;
                init_addr.mode.cas_latency  = mode_cas_latency;
                init_addr.mode.burst_length = mode_burst_length;
                nop_cnt_rst                  = 1'b1;
                next_state                   = init_st_mrs_nop;
            end
            init_st_mrs_nop: if (mrd_nop_end) next_state = init_st_done;
            default: nop_cnt_rst = 1'b1;  // Done, stays here
        endcase
    end

endmodule

`default_nettype wire

//--- hw/sdram_pkg.sv
/*
 * Shared definitions for the SDR SDRAM command controller (200 MHz clock).
 * Holds the command codes, NOP gap counts, power-up and refresh intervals,
 * FSM state codes and the address word union. Imported by every RTL block
 * that issues or checks SDRAM commands.
 */
`default_nettype none

package sdram_pkg;

    // Command codes, ordered {cs_n, ras_n, cas_n, we_n}
    localparam logic [3:0] cmd_nop  = 4'b0111;
    localparam logic [3:0] cmd_pall = 4'b0010;
    localparam logic [3:0] cmd_ref  = 4'b0001;
    localparam logic [3:0] cmd_mrs  = 4'b0000;

    // NOP gap counters
    localparam int                   cnt_width  = 4;
    localparam logic [cnt_width-1:0] t_rp_nops  = 4'd2;  // After PALL
    localparam logic [cnt_width-1:0] t_rc_nops  = 4'd9;  // After REF
    localparam logic [cnt_width-1:0] t_mrd_nops = 4'd2;  // After MRS

    // Power-up wait, 100 us
    localparam int                         init_wait_width = 15;
    localparam logic [init_wait_width-1:0] t_init_wait     = 15'd20000;

    // Refresh interval, 7.8 us
    localparam int                            ref_interval_width = 11;
    localparam logic [ref_interval_width-1:0] t_ref_interval     = 11'd1560;

    // Mode register contents
    localparam logic [2:0] mode_cas_latency  = 3'd2;
    localparam logic [2:0] mode_burst_length = 3'd0;  // Burst of 1

    // Sequencer state codes
    localparam int                     state_width     = 3;
    localparam logic [state_width-1:0] ref_st_idle     = 3'd0;
    localparam logic [state_width-1:0] ref_st_pall     = 3'd1;
    localparam logic [state_width-1:0] ref_st_pall_nop = 3'd2;
    localparam logic [state_width-1:0] ref_st_ref      = 3'd3;
    localparam logic [state_width-1:0] ref_st_ref_nop  = 3'd4;

    localparam logic [state_width-1:0] init_st_wait     = 3'd0;
    localparam logic [state_width-1:0] init_st_pall     = 3'd1;
    localparam logic [state_width-1:0] init_st_pall_nop = 3'd2;
    localparam logic [state_width-1:0] init_st_ref      = 3'd3;
    localparam logic [state_width-1:0] init_st_ref_nop  = 3'd4;
    localparam logic [state_width-1:0] init_st_mrs      = 3'd5;
    localparam logic [state_width-1:0] init_st_mrs_nop  = 3'd6;
    localparam logic [state_width-1:0] init_st_done     = 3'd7;

    // Mode register layout on A12..A0
    typedef struct packed {
        logic [2:0] reserved;
        logic       write_burst_single;
        logic [1:0] op_mode;
        logic [2:0] cas_latency;
        logic       burst_type;
        logic [2:0] burst_length;
    } sdram_mode_t;

    // Address pins, raw or as mode register fields
    typedef union packed {
        logic [12:0] raw;
        sdram_mode_t mode;
    } sdram_addr_u;

endpackage

`default_nettype wire

//--- hw/sdram_ref.sv
/*
 * Auto refresh sequencer. On enable in idle it issues PALL, waits tRP,
 * issues REF, waits tRC and pulses end_ref in the last NOP cycle.
 * The caller holds enable until end_ref; it is only sampled in idle.
 */
`default_nettype none

module sdram_ref (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire logic               enable,
    output logic                    end_ref,
    output logic [3:0]              dram_cmd,
    output sdram_pkg::sdram_addr_u  dram_addr
);

    import sdram_pkg::*;

    logic [state_width-1:0] state;
    logic [state_width-1:0] next_state;
    logic                   nop_cnt_rst;
    logic [cnt_width-1:0]   nop_cnt;
    logic                   pall_nop_end;
    logic                   ref_nop_end;

    // Counter reads 0 in the first NOP cycle
    assign pall_nop_end = (nop_cnt >= t_rp_nops - 1'b1);
    assign ref_nop_end  = (nop_cnt >= t_rc_nops - 1'b1);

    // Only A10 matters here, all banks
    assign dram_addr.raw = 13'h0400;

    sync_parallel_counter #(
        .size       (cnt_width),
        .init_value ('0)
    ) nop_counter (
        .clock      (clock),
        .reset      (nop_cnt_rst),
        .load       (1'b0),
        .load_value ('0),
        .enable     (1'b1),
        .value      (nop_cnt)
    );

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= ref_st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state  = state;
        dram_cmd    = cmd_nop;
        nop_cnt_rst = 1'b0;
        end_ref     = 1'b0;
        case (state)
            ref_st_idle: begin
                nop_cnt_rst = 1'b1;
                if (enable) next_state = ref_st_pall;
            end
            ref_st_pall: begin
                dram_cmd    = cmd_pall;
                nop_cnt_rst = 1'b1;
                next_state  = ref_st_pall_nop;
            end
            ref_st_pall_nop: begin
                if (pall_nop_end) next_state = ref_st_ref;  // tRP met
            end
            ref_st_ref: begin
                dram_cmd    = cmd_ref;
                nop_cnt_rst = 1'b1;
                next_state  = ref_st_ref_nop;
            end
            ref_st_ref_nop: begin
                if (ref_nop_end) begin  // Last tRC NOP
                    end_ref    = 1'b1;
                    next_state = ref_st_idle;
                end
            end
            default: begin
                nop_cnt_rst = 1'b1;
                next_state  = ref_st_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/sdram_refresh_timer.sv
/*
 * Refresh interval timer. Counts while run is high and raises
 * ref_request on the cycle after each wrap, once every 7.8 us.
 * The request is a level that drops after ref_end.
 */
`default_nettype none

module sdram_refresh_timer (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic run,
    input  wire logic ref_end,
    output logic      ref_request
);

    import sdram_pkg::*;

    logic [ref_interval_width-1:0] interval_cnt;
    logic                          wrap;

    assign wrap = run && (interval_cnt == t_ref_interval - 1'b1);

    // Held at zero until init is done
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            interval_cnt <= '0;
        end else if (!run || wrap) begin
            interval_cnt <= '0;
        end else begin
            interval_cnt <= interval_cnt + 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ref_request <= 1'b0;
        end else if (wrap) begin
            ref_request <= 1'b1;
        end else if (ref_end) begin
            ref_request <= 1'b0;  // Served by the sequencer
        end
    end

endmodule

`default_nettype wire

//--- hw/sync_parallel_counter.sv
/*
 * Loadable up counter with enable and synchronous clear.
 * Clear returns it to init_value, load takes load_value.
 * The command sequencers use it to time their NOP gaps.
 */
`default_nettype none

module sync_parallel_counter #(
    parameter int              size       = 4,
    parameter logic [size-1:0] init_value = '0
) (
    input  wire logic            clock,
    input  wire logic            reset,       // Synchronous clear
    input  wire logic            load,
    input  wire logic [size-1:0] load_value,
    input  wire logic            enable,
    output logic      [size-1:0] value
);

    always_ff @(posedge clock) begin
        if (reset) begin
            value <= init_value;
        end else if (load) begin
            value <= load_value;
        end else if (enable) begin
            value <= value + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- list.f
hw/sdram_pkg.sv
hw/sync_parallel_counter.sv
hw/sdram_ref.sv
hw/sdram_init.sv
hw/sdram_refresh_timer.sv
hw/sdram_ctrl_top.sv
sim/sdram_sva.sv
sim/tb_sdram.sv

//--- sim/sdram_sva.sv
/*
 * Assertions on the SDRAM command stream, bound into sdram_ctrl_top.
 * Checks the NOP gaps after PALL and REF, the mode word carried by MRS
 * and the refresh request handshake between timer and sequencer.
 */
`default_nettype none

module sdram_sva (
    input wire logic                   clock,
    input wire logic                   reset,
    input wire logic [3:0]             cmd,
    input wire sdram_pkg::sdram_addr_u addr,
    input wire logic                   ref_request,
    input wire logic                   ref_end
);

    timeunit 1ns;
    timeprecision 1ns;

    import sdram_pkg::*;

    localparam int rp_gap    = t_rp_nops;
    localparam int rc_gap    = t_rc_nops;
    localparam int end_delay = 2 + rp_gap + rc_gap;  // Enable cycle to end_ref

    int sva_errors = 0;  // Read by the testbench at the end

    pall_gap: assert property (@(posedge clock) disable iff (reset)
        cmd == cmd_pall |=> (cmd == cmd_nop) [*rp_gap])
        else begin
            $error("PALL not followed by %0d NOP cycles", rp_gap);
            sva_errors++;
        end

    ref_gap: assert property (@(posedge clock) disable iff (reset)
        cmd == cmd_ref |=> (cmd == cmd_nop) [*rc_gap])
        else begin
            $error("REF not followed by %0d NOP cycles", rc_gap);
            sva_errors++;
        end

    // Mode view of the address pins
    mrs_mode: assert property (@(posedge clock) disable iff (reset)
        cmd == cmd_mrs |-> (addr.mode.cas_latency == mode_cas_latency
                            && addr.mode.burst_length == mode_burst_length))
        else begin
            $error("MRS mode word has wrong CAS latency or burst length");
            sva_errors++;
        end

    // Request held from its rise until the sequencer ends the refresh
    request_held: assert property (@(posedge clock) disable iff (reset)
        $rose(ref_request) |-> (ref_request && !ref_end) [*end_delay]
                               ##1 (ref_request && ref_end))
        else begin
            $error("Refresh request not held until end_ref %0d cycles later", end_delay);
            sva_errors++;
        end

endmodule

bind sdram_ctrl_top sdram_sva sdram_sva_inst (
    .clock       (clock),
    .reset       (reset),
    .cmd         ({dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n}),
    .addr        (dram_addr),
    .ref_request (ref_request),
    .ref_end     (ref_end)
);

`default_nettype wire

//--- sim/tb_sdram.sv
/*
 * Testbench for the SDRAM command controller. Drives clock and reset,
 * samples the command pins on every rising edge and compares them with
 * a model of the power-up sequence and the periodic refresh schedule.
 * Compile with list.f, top module tb_sdram.
 */
`default_nettype none

module tb_sdram;

    timeunit 1ns;
    timeprecision 1ns;

    import sdram_pkg::*;

    typedef struct packed {
        logic [3:0]  cmd;
        logic [12:0] addr;
        logic        ready;
        logic        refresh_active;
    } pins_t;

    typedef struct packed {
        logic        in_reset;
        logic [31:0] idx;
        pins_t       pins;
        logic        cke;
        logic [1:0]  ba;
    } sample_t;

    localparam int clock_period = 100;
    localparam int init_wait    = int'(t_init_wait);
    localparam int interval     = int'(t_ref_interval);
    localparam int run_cycles   = init_wait + 60 + 4 * interval;
    localparam int cycle_limit  = run_cycles + run_cycles / 10;

    // Power-up milestones in cycles after reset release
    localparam int pall_at  = init_wait;
    localparam int ref1_at  = pall_at + 1 + int'(t_rp_nops);
    localparam int ref2_at  = ref1_at + 1 + int'(t_rc_nops);
    localparam int mrs_at   = ref2_at + 1 + int'(t_rc_nops);
    localparam int ready_at = mrs_at + 1 + int'(t_mrd_nops);

    // Periodic refresh offsets from the enable cycle
    localparam int ref_phase   = 2 + int'(t_rp_nops);
    localparam int last_active = ref_phase + int'(t_rc_nops);

    logic        clock;
    logic        reset;
    logic        ready;
    logic        refresh_active;
    logic        dram_cke;
    logic        dram_cs_n;
    logic        dram_ras_n;
    logic        dram_cas_n;
    logic        dram_we_n;
    logic [12:0] dram_addr;
    logic [1:0]  dram_ba;

    sample_t sample_q[$];
    int      cycle_idx   = 0;
    int      reset_edges = 0;
    int      compared    = 0;
    int      check_count = 0;
    int      error_count = 0;
    int      cycle_count = 0;

    sdram_ctrl_top sdram_ctrl_top_inst (
        .clock          (clock),
        .reset          (reset),
        .ready          (ready),
        .refresh_active (refresh_active),
        .dram_cke       (dram_cke),
        .dram_cs_n      (dram_cs_n),
        .dram_ras_n     (dram_ras_n),
        .dram_cas_n     (dram_cas_n),
        .dram_we_n      (dram_we_n),
        .dram_addr      (dram_addr),
        .dram_ba        (dram_ba)
    );

    function automatic pins_t expected_cmd(input int idx);
        pins_t exp;
        int    offset;
        int    phase;
        exp.cmd            = cmd_nop;
        exp.addr           = '0;
        exp.ready          = 1'b0;
        exp.refresh_active = 1'b0;
        if (idx < ready_at) begin
            if (idx == pall_at) begin
                exp.cmd  = cmd_pall;
                exp.addr = 13'h0400;  // A10 selects all banks
            end else if (idx == ref1_at || idx == ref2_at) begin
                exp.cmd = cmd_ref;
            end else if (idx == mrs_at) begin
                exp.cmd  = cmd_mrs;
                // Zero reserved, write burst, op mode and burst type
                exp.addr = {6'b0, mode_cas_latency, 1'b0, mode_burst_length};
            end
        end else begin
            exp.ready = 1'b1;
            exp.addr  = 13'h0400;  // Refresh side holds A10
            offset    = idx - ready_at;
            phase     = offset % interval;
            if (offset >= interval) begin  // No request in the first interval
                exp.refresh_active = (phase <= last_active);
                if (phase == 1) exp.cmd = cmd_pall;
                else if (phase == ref_phase) exp.cmd = cmd_ref;
            end
        end
        return exp;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // Values from the cycle that ends at this edge
    always @(posedge clock) begin : monitor
        sample_t s;
        s.in_reset = reset;
        s.idx      = cycle_idx;
        s.pins     = {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n, dram_addr,
                      ready, refresh_active};
        s.cke      = dram_cke;
        s.ba       = dram_ba;
        if (reset) reset_edges++;
        // Flops hold their reset values only after the first reset edge
        if (!reset || reset_edges > 1) sample_q.push_back(s);
        if (!reset) cycle_idx++;
    end

    always @(negedge clock) begin : compare
        sample_t s;
        pins_t   exp;
        string   at;
        while (sample_q.size() > 0) begin
            s = sample_q.pop_front();
            if (s.in_reset) begin
                check_value("cmd in reset", s.pins.cmd, cmd_nop);
                check_value("ready in reset", s.pins.ready, 1'b0);
                check_value("refresh_active in reset", s.pins.refresh_active, 1'b0);
                check_value("dram_cke in reset", s.cke, 1'b0);
            end else begin
                exp = expected_cmd(s.idx);
                at  = $sformatf(" at cycle %0d", s.idx);
                check_value({"cmd", at}, s.pins.cmd, exp.cmd);
                check_value({"dram_addr", at}, s.pins.addr, exp.addr);
                check_value({"ready", at}, s.pins.ready, exp.ready);
                check_value({"refresh_active", at}, s.pins.refresh_active,
                            exp.refresh_active);
                check_value({"dram_ba", at}, s.ba, 2'b00);
                check_value({"dram_cke", at}, s.cke, s.idx != 0);  // Registered
                compared++;
            end
        end
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        while (compared < run_cycles) @(posedge clock);
        check_value("assertion failures", sdram_ctrl_top_inst.sdram_sva_inst.sva_errors, 0);
        $display("Checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles without finishing", cycle_limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
